// ==== all.f ====
+incdir+.
core_pkg.sv
pipe_reg.sv
decode_unit.sv
regfile.sv
issue_unit.sv
alu_lane.sv
dual_issue_core.sv
core_chk.sv
tb_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_core
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FLIST     ?= all.f
VFLAGS    ?= --binary --timing --assert

SRCS := $(wildcard *.sv *.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_core.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module tb_core
    import core_pkg::*;
();

    localparam int READY_TIMEOUT = 20;
    localparam int DRAIN_TIMEOUT = 50;

    typedef struct {
        word_t i0;
        word_t i1;
        word_t d0;
        word_t d1;
        bit    split;
    } row_t;

    // paired: lane 1 of a pair that must commit alongside its lane 0
    typedef struct packed {
        reg_addr_t rd;
        word_t     data;
        logic      paired;
    } expect_t;

    logic         clk;
    logic         resetn;
    logic         in_valid;
    logic         in_ready;
    fetch_pair_t  in_pair;
    result_pair_t commit;

    row_t        rows[$];
    expect_t     exp_q[$];
    word_t       model_regs [`REG_COUNT];
    int          errors;
    bit          timed_out;
    logic [31:0] lfsr;

    dual_issue_core i_dual_issue_core (
        .clk,
        .resetn,
        .in_valid,
        .in_ready,
        .in_pair,
        .commit
    );

    bind dual_issue_core core_chk i_core_chk (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic word_t enc_r(input logic [5:0] fn, input reg_addr_t rs,
                                    input reg_addr_t rt, input reg_addr_t rd,
                                    input logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t enc_i(input logic [5:0] opc, input reg_addr_t rs,
                                    input reg_addr_t rt, input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t rand_instr();
        logic [3:0]  kind;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [4:0]  sh;
        logic [15:0] imm;
        kind = 4'(rand_bits(4));
        // small register range so dependencies are frequent
        rs   = 5'(rand_bits(3));
        rt   = 5'(rand_bits(3));
        rd   = 5'(rand_bits(3));
        sh   = 5'(rand_bits(5));
        imm  = 16'(rand_bits(16));
        case (kind)
            4'd0: return enc_r(6'h21, rs, rt, rd, 5'd0);
            4'd1: return enc_r(6'h23, rs, rt, rd, 5'd0);
            4'd2: return enc_r(6'h24, rs, rt, rd, 5'd0);
            4'd3: return enc_r(6'h25, rs, rt, rd, 5'd0);
            4'd4: return enc_r(6'h26, rs, rt, rd, 5'd0);
            4'd5: return enc_r(6'h2a, rs, rt, rd, 5'd0);
            4'd6: return enc_r(6'h00, 5'd0, rt, rd, sh);
            4'd9: return enc_i(6'h0d, rs, rt, imm);
            4'd10: return enc_i(6'h0f, 5'd0, rt, imm);
            // lw and jr are not supported
            4'd11: return enc_i(6'h23, rs, rt, imm);
            4'd12: return enc_r(6'h08, rs, rt, rd, 5'd0);
            default: return enc_i(6'h09, rs, rt, imm);
        endcase
    endfunction

    // in-order reference, one instruction at a time
    task automatic ref_exec(input word_t ins, output bit w, output reg_addr_t rd,
                            output word_t data);
        logic [5:0] opc;
        logic [5:0] fn;
        word_t      a;
        word_t      b;
        bit         ok;
        opc  = ins[31:26];
        fn   = ins[5:0];
        a    = model_regs[ins[25:21]];
        b    = model_regs[ins[20:16]];
        ok   = 1'b1;
        data = '0;
        rd   = (opc == 6'h00) ? ins[15:11] : ins[20:16];
        case (opc)
            6'h00: begin
                case (fn)
                    6'h21: data = a + b;
                    6'h23: data = a - b;
                    6'h24: data = a & b;
                    6'h25: data = a | b;
                    6'h26: data = a ^ b;
                    6'h2a: data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    6'h00: data = b << ins[10:6];
                    default: ok = 1'b0;
                endcase
            end
            6'h09: data = a + {{16{ins[15]}}, ins[15:0]};
            6'h0d: data = a | {16'h0000, ins[15:0]};
            6'h0f: data = {ins[15:0], 16'h0000};
            default: ok = 1'b0;
        endcase
        w = ok && (rd != '0);
        if (w) begin
            model_regs[rd] = data;
        end
    endtask

    task automatic push_expect(input word_t ins, input word_t tab_data, input bit use_tab,
                               input bit paired);
        bit        w;
        reg_addr_t rd;
        word_t     data;
        ref_exec(ins, w, rd, data);
        if (w) begin
            exp_q.push_back('{rd: rd, data: use_tab ? tab_data : data, paired: paired});
        end
    endtask

    task automatic send_pair(input word_t i0, input word_t i1, input bit split);
        int waits;
        bit ok;
        in_valid <= 1'b1;
        in_pair  <= fetch_pair_t'({i1, i0});
        ok    = 1'b0;
        waits = 0;
        while (!ok && waits < READY_TIMEOUT) begin
            @(negedge clk);
            ok = in_ready;
            @(posedge clk);
            waits++;
        end
        if (!ok) begin
            $display("timeout at %0t: in_ready never rose", $time);
            timed_out = 1'b1;
        end else if (split) begin
            in_valid <= 1'b0;
            @(negedge clk);
            if (in_ready !== 1'b0) begin
                errors++;
                $display("error at %0t: in_ready = %b, expected 0", $time, in_ready);
            end
            @(posedge clk);
        end
    endtask

    task automatic check_commit(input int i);
        expect_t e;
        if (exp_q.size() == 0) begin
            errors++;
            $display("lane %0d committed a write to r%0d that was not expected",
                     i, commit.lane[i].rd);
        end else begin
            e = exp_q.pop_front();
            if (commit.lane[i].rd !== e.rd) begin
                errors++;
                $display("error at %0t: commit.lane[%0d].rd = %0d, expected %0d",
                         $time, i, commit.lane[i].rd, e.rd);
            end
            if (commit.lane[i].data !== e.data) begin
                errors++;
                $display("error at %0t: commit.lane[%0d].data = %h, expected %h",
                         $time, i, commit.lane[i].data, e.data);
            end
            if (e.paired && !(i == 1 && commit.lane[0].valid && commit.lane[0].writes)) begin
                errors++;
                $display("at %0t the lanes of an independent pair committed in different cycles",
                         $time);
            end
        end
    endtask

    // lane 0 is older, checked first
    always @(negedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < `LANES; i++) begin
                if (commit.lane[i].valid && commit.lane[i].writes) begin
                    check_commit(i);
                end
            end
        end
    end

    task automatic build_rows();
        rows.push_back('{enc_i(6'h09, 0, 1, 16'd5), enc_i(6'h09, 0, 2, 16'hfffd),
                         32'd5, 32'hffff_fffd, 1'b0});
        rows.push_back('{enc_i(6'h0d, 0, 3, 16'h8000), enc_i(6'h0f, 0, 4, 16'h1234),
                         32'h0000_8000, 32'h1234_0000, 1'b0});
        rows.push_back('{enc_r(6'h21, 1, 2, 5, 0), enc_r(6'h23, 1, 2, 6, 0),
                         32'd2, 32'd8, 1'b0});
        rows.push_back('{enc_r(6'h24, 3, 4, 7, 0), enc_r(6'h25, 5, 6, 8, 0),
                         32'd0, 32'd10, 1'b0});
        rows.push_back('{enc_r(6'h26, 4, 3, 9, 0), enc_r(6'h2a, 2, 1, 10, 0),
                         32'h1234_8000, 32'd1, 1'b0});
        rows.push_back('{enc_r(6'h00, 0, 1, 11, 4), enc_r(6'h2a, 1, 2, 12, 0),
                         32'd80, 32'd0, 1'b0});
        // younger reads the older destination
        rows.push_back('{enc_i(6'h09, 1, 13, 16'd1), enc_r(6'h21, 13, 13, 14, 0),
                         32'd6, 32'd12, 1'b1});
        rows.push_back('{enc_i(6'h09, 0, 15, 16'd7), enc_i(6'h09, 0, 15, 16'd9),
                         32'd7, 32'd9, 1'b0});
        // r0 written here, read back by the next pair
        rows.push_back('{enc_r(6'h21, 15, 0, 16, 0), enc_i(6'h09, 1, 0, 16'd9),
                         32'd9, 32'd0, 1'b0});
        rows.push_back('{32'hffff_ffff, enc_r(6'h21, 0, 0, 17, 0),
                         32'd0, 32'd0, 1'b0});
    endtask

    initial begin
        int    waits;
        int    depth;
        word_t i0;
        word_t i1;
        errors    = 0;
        timed_out = 1'b0;
        lfsr      = 32'h2903_74c0;
        resetn    = 1'b1;
        in_valid  = 1'b0;
        in_pair   = '0;
        for (int r = 0; r < `REG_COUNT; r++) begin
            model_regs[r] = '0;
        end
        build_rows();
        repeat (2) @(posedge clk);
        resetn <= 1'b0;
        @(negedge clk);
        if (in_ready !== 1'b1) begin
            errors++;
            $display("error at %0t: in_ready = %b, expected 1", $time, in_ready);
        end
        if (commit.lane[0].valid !== 1'b0 || commit.lane[1].valid !== 1'b0) begin
            errors++;
            $display("error at %0t: commit valid = %b%b, expected 00", $time,
                     commit.lane[1].valid, commit.lane[0].valid);
        end
        @(posedge clk);
        foreach (rows[n]) begin
            if (!timed_out) begin
                depth = exp_q.size();
                push_expect(rows[n].i0, rows[n].d0, 1'b1, 1'b0);
                push_expect(rows[n].i1, rows[n].d1, 1'b1,
                            !rows[n].split && exp_q.size() != depth);
                send_pair(rows[n].i0, rows[n].i1, rows[n].split);
            end
        end
        for (int n = 0; n < 200 && !timed_out; n++) begin
            i0 = rand_instr();
            i1 = rand_instr();
            push_expect(i0, '0, 1'b0, 1'b0);
            push_expect(i1, '0, 1'b0, 1'b0);
            send_pair(i0, i1, 1'b0);
        end
        in_valid <= 1'b0;
        waits = 0;
        while (exp_q.size() != 0 && waits < DRAIN_TIMEOUT) begin
            @(posedge clk);
            waits++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d expected commits never arrived", exp_q.size());
            timed_out = 1'b1;
        end
        repeat (4) @(posedge clk);
        $display("errors: %0d, timeout: %0d", errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== core_chk.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module core_chk
    import core_pkg::*;
(
    input logic         clk,
    input logic         resetn,
    input logic         in_valid,
    input logic         in_ready,
    input fetch_pair_t  in_pair,
    input result_pair_t commit
);

    a_idle_after_reset: assert property (@(posedge clk)
        $fell(resetn) |-> !(commit.lane[0].valid || commit.lane[1].valid))
        else $error("commit valid in the first cycle after reset");

    // a split stalls the input for one cycle only
    a_ready_one_cycle: assert property (@(posedge clk) disable iff (resetn)
        !in_ready |=> in_ready)
        else $error("in_ready low for two cycles in a row");

    a_no_r0_lane0: assert property (@(posedge clk) disable iff (resetn)
        (commit.lane[0].valid && commit.lane[0].writes) |-> commit.lane[0].rd != '0)
        else $error("lane 0 commits a write to r0");

    a_no_r0_lane1: assert property (@(posedge clk) disable iff (resetn)
        (commit.lane[1].valid && commit.lane[1].writes) |-> commit.lane[1].rd != '0)
        else $error("lane 1 commits a write to r0");

    a_pair_stable: assert property (@(posedge clk) disable iff (resetn)
        (in_valid && !in_ready) |=> $stable(in_pair))
        else $error("in_pair changed while stalled");

endmodule

// ==== dual_issue_core.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module dual_issue_core
    import core_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,
    input  logic         in_valid,
    output logic         in_ready,
    input  fetch_pair_t  in_pair,
    output result_pair_t commit
);

    decoded_pair_t            dec_next;
    decoded_pair_t            dec_q;
    issued_pair_t             iss_next;
    issued_pair_t             ex_q;
    result_pair_t             ex_res;
    result_pair_t             wb_q;
    reg_addr_t [2*`LANES-1:0] rf_addr;
    word_t     [2*`LANES-1:0] rf_data;
    logic                     hold;

    assign in_ready = ~hold;
    assign commit   = wb_q;

    decode_unit i_decode_unit (
        .pair    (in_pair),
        .decoded (dec_next)
    );

    // held during a split, bubble when nothing transfers
    pipe_reg #(.T(decoded_pair_t)) i_decode_reg (
        .clk,
        .resetn,
        .en    (~hold),
        .flush (~hold & ~in_valid),
        .d     (dec_next),
        .q     (dec_q)
    );

    regfile i_regfile (
        .clk,
        .resetn,
        .ra (rf_addr),
        .rd (rf_data),
        .wr (wb_q)
    );

    issue_unit i_issue_unit (
        .clk,
        .resetn,
        .decoded (dec_q),
        .rf_addr (rf_addr),
        .rf_data (rf_data),
        .ex_fwd  (ex_res),
        .wb_fwd  (wb_q),
        .issued  (iss_next),
        .hold    (hold)
    );

    pipe_reg #(.T(issued_pair_t)) i_execute_reg (
        .clk,
        .resetn,
        .en    (1'b1),
        .flush (1'b0),
        .d     (iss_next),
        .q     (ex_q)
    );

    for (genvar i = 0; i < `LANES; i++) begin : g_lane
        alu_lane i_alu_lane (
            .lane_in  (ex_q.lane[i]),
            .lane_out (ex_res.lane[i])
        );
    end

    // no back-pressure from commit
    pipe_reg #(.T(result_pair_t)) i_writeback_reg (
        .clk,
        .resetn,
        .en    (1'b1),
        .flush (1'b0),
        .d     (ex_res),
        .q     (wb_q)
    );

endmodule

// ==== alu_lane.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module alu_lane
    import core_pkg::*;
(
    input  issued_t lane_in,
    output result_t lane_out
);

    word_t a;
    word_t b;
    word_t res;

    assign a = lane_in.src_a;
    assign b = lane_in.src_b;

    always_comb begin
        res = '0;
        case (lane_in.op)
            OP_ADD: res = a + b;
            OP_SUB: res = a - b;
            OP_AND: res = a & b;
            OP_OR:  res = a | b;
            OP_XOR: res = a ^ b;
            // signed compare
            OP_SLT: res = word_t'($signed(a) < $signed(b));
            OP_SLL: res = b << a[$clog2(`XLEN)-1:0];
            OP_LUI: res = {b[`XLEN/2-1:0], {(`XLEN/2){1'b0}}};
        endcase
    end

    assign lane_out.valid  = lane_in.valid;
    assign lane_out.rd     = lane_in.rd;
    assign lane_out.writes = lane_in.writes;
    assign lane_out.data   = res;

endmodule

// ==== issue_unit.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module issue_unit
    import core_pkg::*;
(
    input  logic                     clk,
    input  logic                     resetn,
    input  decoded_pair_t            decoded,
    output reg_addr_t [2*`LANES-1:0] rf_addr,
    input  word_t     [2*`LANES-1:0] rf_data,
    input  result_pair_t             ex_fwd,
    input  result_pair_t             wb_fwd,
    output issued_pair_t             issued,
    output logic                     hold
);

    logic              second_half;
    logic              dep;
    logic [`LANES-1:0] issue_en;

    function automatic logic hits(input result_t r, input reg_addr_t a);
        return r.valid && r.writes && (r.rd == a);
    endfunction

    // lowest priority first, later matches override
    function automatic word_t resolve(input reg_addr_t a, input word_t rf_val,
                                      input result_pair_t ex, input result_pair_t wb);
        word_t v;
        v = rf_val;
        for (int i = 0; i < `LANES; i++) begin
            if (hits(wb.lane[i], a)) begin
                v = wb.lane[i].data;
            end
        end
        for (int i = 0; i < `LANES; i++) begin
            if (hits(ex.lane[i], a)) begin
                v = ex.lane[i].data;
            end
        end
        return v;
    endfunction

    // younger lane reads what the older lane writes
    assign dep = decoded.lane[0].valid && decoded.lane[0].writes && decoded.lane[1].valid
               && ((decoded.lane[1].rs == decoded.lane[0].rd)
                   || (!decoded.lane[1].use_imm && decoded.lane[1].rt == decoded.lane[0].rd));

    assign hold        = dep && !second_half;
    assign issue_en[0] = !second_half;
    assign issue_en[1] = second_half || !dep;

    always_ff @(posedge clk) begin
        if (resetn) begin
            second_half <= 1'b0;
        end else begin
            second_half <= hold;
        end
    end

    always_comb begin
        for (int i = 0; i < `LANES; i++) begin
            rf_addr[2*i]   = decoded.lane[i].rs;
            rf_addr[2*i+1] = decoded.lane[i].rt;
        end
    end

    always_comb begin
        for (int i = 0; i < `LANES; i++) begin
            issued.lane[i] = '0;
            if (issue_en[i] && decoded.lane[i].valid) begin
                issued.lane[i].valid  = 1'b1;
                issued.lane[i].op     = decoded.lane[i].op;
                issued.lane[i].rd     = decoded.lane[i].rd;
                issued.lane[i].writes = decoded.lane[i].writes;
                issued.lane[i].src_a  = resolve(decoded.lane[i].rs, rf_data[2*i],
                                                ex_fwd, wb_fwd);
                if (decoded.lane[i].use_imm) begin
                    issued.lane[i].src_b = decoded.lane[i].imm;
                end else begin
                    issued.lane[i].src_b = resolve(decoded.lane[i].rt, rf_data[2*i+1],
                                                   ex_fwd, wb_fwd);
                end
                // sll takes its shift amount on the a side
                if (decoded.lane[i].op == OP_SLL) begin
                    issued.lane[i].src_a = word_t'(decoded.lane[i].shamt);
                end
            end
        end
    end

endmodule

// ==== regfile.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module regfile
    import core_pkg::*;
(
    input  logic                     clk,
    input  logic                     resetn,
    input  reg_addr_t [2*`LANES-1:0] ra,
    output word_t     [2*`LANES-1:0] rd,
    input  result_pair_t             wr
);

    // r0 has no storage
    word_t regs [1:`REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int r = 1; r < `REG_COUNT; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // higher lane applied last, wins a clash
            for (int i = 0; i < `LANES; i++) begin
                if (wr.lane[i].valid && wr.lane[i].writes && wr.lane[i].rd != '0) begin
                    regs[wr.lane[i].rd] <= wr.lane[i].data;
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 2*`LANES; p++) begin
            rd[p] = (ra[p] == '0) ? '0 : regs[ra[p]];
        end
    end

endmodule

// ==== decode_unit.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module decode_unit
    import core_pkg::*;
(
    input  fetch_pair_t   pair,
    output decoded_pair_t decoded
);

    function automatic decoded_t decode_one(input word_t instr);
        decoded_t   d;
        logic [5:0] opcode;
        logic [5:0] funct;
        logic       supported;
        opcode    = instr[31:26];
        funct     = instr[5:0];
        supported = 1'b1;
        d         = '0;
        d.valid   = 1'b1;
        d.rs      = instr[25:21];
        d.rt      = instr[20:16];
        d.shamt   = instr[10:6];
        if (opcode == OPC_SPECIAL) begin
            d.rd = instr[15:11];
            case (funct)
                FN_ADDU: d.op = OP_ADD;
                FN_SUBU: d.op = OP_SUB;
                FN_AND:  d.op = OP_AND;
                FN_OR:   d.op = OP_OR;
                FN_XOR:  d.op = OP_XOR;
                FN_SLT:  d.op = OP_SLT;
                FN_SLL: begin
                    // shifts rt only, rs is not a source
                    d.op = OP_SLL;
                    d.rs = '0;
                end
                default: supported = 1'b0;
            endcase
        end else begin
            d.rd      = instr[20:16];
            d.use_imm = 1'b1;
            case (opcode)
                OPC_ADDIU: begin
                    d.op  = OP_ADD;
                    d.imm = {{(`XLEN-16){instr[15]}}, instr[15:0]};
                end
                OPC_ORI: begin
                    d.op  = OP_OR;
                    d.imm = {{(`XLEN-16){1'b0}}, instr[15:0]};
                end
                OPC_LUI: begin
                    d.op  = OP_LUI;
                    d.rs  = '0;
                    d.imm = {{(`XLEN-16){1'b0}}, instr[15:0]};
                end
                default: supported = 1'b0;
            endcase
        end
        // unsupported encodings read nothing, so they never cause a split
        if (!supported) begin
            d.rs      = '0;
            d.rt      = '0;
            d.use_imm = 1'b1;
        end
        d.writes = supported && (d.rd != '0);
        return d;
    endfunction

    always_comb begin
        for (int i = 0; i < `LANES; i++) begin
            decoded.lane[i] = decode_one(pair.instr[i]);
        end
    end

endmodule

// ==== pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic resetn,
    input  logic en,
    input  logic flush,
    input  T     d,
    output T     q
);

    // all-zero clears every valid bit in the payload
    always_ff @(posedge clk) begin
        if (resetn || flush) begin
            q <= '0;
        end else if (en) begin
            q <= d;
        end
    end

endmodule

// ==== core_pkg.sv ====
`include "core_config.svh"

package core_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLL,
        OP_LUI
    } alu_op_t;

    // primary opcodes
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_LUI     = 6'h0f;

    // funct codes under SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    // lane 0 holds the older instruction
    typedef struct packed {
        word_t [`LANES-1:0] instr;
    } fetch_pair_t;

    typedef struct packed {
        logic      valid;
        alu_op_t   op;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic      writes;
        logic      use_imm;
        word_t     imm;
        logic [4:0] shamt;
    } decoded_t;

    typedef struct packed {
        decoded_t [`LANES-1:0] lane;
    } decoded_pair_t;

    typedef struct packed {
        logic      valid;
        alu_op_t   op;
        reg_addr_t rd;
        logic      writes;
        word_t     src_a;
        word_t     src_b;
    } issued_t;

    typedef struct packed {
        issued_t [`LANES-1:0] lane;
    } issued_pair_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        logic      writes;
        word_t     data;
    } result_t;

    typedef struct packed {
        result_t [`LANES-1:0] lane;
    } result_pair_t;

endpackage

// ==== core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// data and instruction width
`define XLEN 32

// architectural registers, r0 reads as zero
`define REG_COUNT 32

// instructions per fetched pair
`define LANES 2

`endif
